// File: sources.f
design/motion_pkg.sv
design/cmd_pkg.sv
design/dda_axis.sv
design/move_queue.sv
design/cmd_decoder.sv
design/motion_top.sv
tb/motion_tb.sv

// File: Bender.yml
package:
  name: motion_ctrl

sources:
  - design/motion_pkg.sv
  - design/cmd_pkg.sv
  - design/dda_axis.sv
  - design/move_queue.sv
  - design/cmd_decoder.sv
  - design/motion_top.sv
  - target: test
    files:
      - tb/motion_tb.sv

// File: tb/motion_tests.txt
# name word_count, then word/reply pairs in hex, then steps per axis and positions per axis
# Positions are cumulative over the run and are read back after every move has finished
api_version 1
fe00000000000000 0000000000010203
0 0 0 0
motor_enable 2
0a00000000000003 0 0a00000000000001 0
0 0 0 0
single_move 6
0100000000000001 0 0000000000000008 0 4000000000000000 0
0000000000000000 0 0000000000000000 0 2000000000000000 0
2 3 2 -3
two_moves 12
0100000000000003 0 0000000000000008 0 4000000000000000 0
0000000000000000 0 8000000000000000 0 0000000000000000 0
0100000000000002 0 0000000000000008 0 8000000000000000 0
0000000000000000 0 0000000000000000 0 2000000000000000 0
6 7 0 4
clk_divisor 7
2000000000000003 0 0100000000000001 0 0000000000000008 0
4000000000000000 0 0000000000000000 0 0000000000000000 0
2000000000000000 0
2 3 2 1
move_reply 7
5500000000000000 0 0100000000000000 0 0000000000000004 0
c000000000000000 0 0000000000000000 0 ffffffffffffffff 0
0000000000000000 0
3 3 -1 -2

// File: tb/motion_tb.sv
// Motion controller testbench
`timescale 1ns/1ps

module motion_tb import motion_pkg::*, cmd_pkg::*; ();

  localparam int TIMEOUT = 20000; // Clock cycles allowed per wait

  logic        CLK;
  logic        resetn;
  word_t       word_data;
  logic        word_valid;
  word_t       reply_data;
  logic        buffer_ready;
  logic        move_done;
  axis_mask_t  step;
  axis_mask_t  dir;
  axis_mask_t  enable;

  int          errors;
  int          cycle;
  int          done_cnt;
  int          moves_sent;
  int          words_left;            // Words still due in the current move
  int          div_eff = DEFAULT_DIVISOR;
  duration_t   cur_dur;
  int          step_cnt [NUM_AXES];
  int          last_word_cycle [$];
  int          min_latency [$];       // Ticks times divisor, per queued move
  axis_mask_t  move_dirs [$];         // Direction mask per queued move
  logic [31:0] rng_state;

  motion_top motion_top_i (
    .CLK          (CLK),
    .resetn       (resetn),
    .word_data    (word_data),
    .word_valid   (word_valid),
    .reply_data   (reply_data),
    .buffer_ready (buffer_ready),
    .move_done    (move_done),
    .step         (step),
    .dir          (dir),
    .enable       (enable)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_err(input string msg);
    $display("ERR %0t %s", $time, msg);
    errors++;
  endtask

  task automatic abort_run(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TEST FAILED");
    $finish;
  endtask

  // Step, dir and move_done monitor
  always @(posedge CLK) begin : monitor
    int lat;
    int min_lat;
    cycle++;
    if (!resetn) begin
      for (int a = 0; a < NUM_AXES; a++) begin
        if (step[a]) step_cnt[a]++;
        // The last step of a move shares its cycle with move_done
        if (step[a] && !move_done && move_dirs.size() != 0) begin
          if (dir[a] !== move_dirs[0][a]) begin
            report_err($sformatf("axis %0d stepped with dir %b, expected %b",
                                 a, dir[a], move_dirs[0][a]));
          end
        end
      end
      if (move_done) begin
        done_cnt++;
        if (!buffer_ready) report_err("buffer_ready low after move_done");
        if (last_word_cycle.size() == 0) begin
          report_err("move_done without a queued move");
        end else begin
          lat     = cycle - last_word_cycle.pop_front();
          min_lat = min_latency.pop_front();
          void'(move_dirs.pop_front());
          if (lat < min_lat) begin
            report_err($sformatf("move took %0d cycles, expected at least %0d", lat, min_lat));
          end
        end
      end
    end
  end

  task automatic wait_buffer_ready();
    int n;
    n = 0;
    @(negedge CLK);
    while (!buffer_ready && n < TIMEOUT) begin
      @(negedge CLK);
      n++;
    end
    if (!buffer_ready) abort_run("buffer_ready before a move header");
  endtask

  task automatic wait_moves_done();
    int n;
    n = 0;
    while (done_cnt != moves_sent && n < TIMEOUT) begin
      @(negedge CLK);
      n++;
    end
    if (done_cnt != moves_sent) abort_run("move_done of every queued move");
  endtask

  // One strobed word, its reply and the header side effects
  task automatic send_word(input word_t w, input word_t exp_reply);
    logic       is_header;
    logic [7:0] op;
    is_header = (words_left == 0);
    op        = w[HEADER_MSB:HEADER_LSB];
    if (is_header && op == CMD_COORDINATED_STEP) wait_buffer_ready();
    @(posedge CLK);
    word_data  <= w;
    word_valid <= 1'b1;
    @(posedge CLK);
    word_valid <= 1'b0;
    @(negedge CLK);
    if (reply_data !== exp_reply) begin
      report_err($sformatf("word %h replied %h, expected %h", w, reply_data, exp_reply));
    end
    if (is_header) begin
      if (op == CMD_COORDINATED_STEP) begin
        words_left = MOVE_WORDS - 1;
        moves_sent++;
        move_dirs.push_back(w[NUM_AXES-1:0]);
      end
      if (op == CMD_MOTOR_ENABLE && enable !== w[1:0]) begin
        report_err($sformatf("enable is %b, expected %b", enable, w[1:0]));
      end
      if (op == CMD_CLK_DIVISOR) div_eff = (w[7:0] == 8'd0) ? 1 : int'(w[7:0]);
    end else begin
      if (words_left == MOVE_WORDS - 1) cur_dur = w[31:0]; // Duration follows the header
      words_left--;
      if (words_left == 0) begin
        last_word_cycle.push_back(cycle);
        min_latency.push_back(int'(cur_dur) * div_eff);
        @(negedge CLK); // Slot flag settles one cycle after the push
        if ((moves_sent - done_cnt == BUFFER_SIZE) == buffer_ready) begin
          report_err($sformatf("buffer_ready is %b with %0d moves queued",
                               buffer_ready, moves_sent - done_cnt));
        end
      end
    end
    rng_state = xorshift(rng_state);
    repeat (1 + rng_state[1:0]) @(posedge CLK);
  endtask

  initial begin
    int                fd;
    int                code;
    int                nwords;
    int                passed;
    int                failed;
    int                err_start;
    int                exp_steps [NUM_AXES];
    int                exp_pos [NUM_AXES];
    string             name;
    logic [8*128-1:0]  skip_line;
    word_t             w;
    word_t             r;
    resetn     = 1'b1;
    word_valid = 1'b0;
    word_data  = '0;
    rng_state  = 32'd19031;
    passed     = 0;
    failed     = 0;
    repeat (5) @(posedge CLK);
    resetn <= 1'b0;
    @(negedge CLK);
    err_start = errors;
    if (enable !== '0 || move_done !== 1'b0 || buffer_ready !== 1'b1 || reply_data !== '0) begin
      report_err("outputs differ from their reset values");
    end
    if (errors == err_start) begin
      passed++;
      $display("reset: PASS");
    end else begin
      failed++;
      $display("reset: FAIL");
    end

    fd = $fopen("tb/motion_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/motion_tests.txt");
      errors++;
    end
    while (fd != 0 && $fscanf(fd, "%s", name) == 1) begin
      if (name.getc(0) == "#") begin
        code = $fgets(skip_line, fd); // Rest of a comment line
      end else begin
        err_start = errors;
        for (int a = 0; a < NUM_AXES; a++) step_cnt[a] = 0;
        code = $fscanf(fd, "%d", nwords);
        for (int i = 0; i < nwords; i++) begin
          code = $fscanf(fd, "%h %h", w, r);
          send_word(w, r);
        end
        for (int a = 0; a < NUM_AXES; a++) code = $fscanf(fd, "%d", exp_steps[a]);
        for (int a = 0; a < NUM_AXES; a++) code = $fscanf(fd, "%d", exp_pos[a]);
        wait_moves_done();
        for (int a = 0; a < NUM_AXES; a++) begin
          send_word({CMD_READ_POSITION, 8'(a), 48'd0}, word_t'(longint'(exp_pos[a])));
          if (step_cnt[a] != exp_steps[a]) begin
            report_err($sformatf("axis %0d made %0d steps, expected %0d",
                                 a, step_cnt[a], exp_steps[a]));
          end
        end
        if (errors == err_start) begin
          passed++;
          $display("%s: PASS", name);
        end else begin
          failed++;
          $display("%s: FAIL", name);
        end
      end
    end
    if (fd != 0) $fclose(fd);

    $display("Tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: design/motion_top.sv
// Two axis motion controller
`timescale 1ns/1ps

module motion_top import motion_pkg::*, cmd_pkg::*; (
  input  logic        CLK,
  input  logic        resetn,
  input  word_t       word_data,
  input  logic        word_valid,
  output word_t       reply_data,
  output logic        buffer_ready,
  output logic        move_done,
  output axis_mask_t  step,
  output axis_mask_t  dir,
  output axis_mask_t  enable
);

  divisor_t                  divisor;
  move_rec_t                 move_wr;
  slot_idx_t                 move_wr_slot;
  logic                      move_wr_push;
  axis_cmd_t [NUM_AXES-1:0]  axis_cmd;
  position_t [NUM_AXES-1:0]  position;
  logic                      tick;
  logic                      load;
  logic                      run;

  cmd_decoder cmd_decoder_i (
    .CLK          (CLK),
    .resetn       (resetn),
    .word_data    (word_data),
    .word_valid   (word_valid),
    .position     (position),
    .reply_data   (reply_data),
    .enable       (enable),
    .divisor      (divisor),
    .move_wr      (move_wr),
    .move_wr_slot (move_wr_slot),
    .move_wr_push (move_wr_push)
  );

  move_queue move_queue_i (
    .CLK          (CLK),
    .resetn       (resetn),
    .divisor      (divisor),
    .move_wr      (move_wr),
    .move_wr_slot (move_wr_slot),
    .move_wr_push (move_wr_push),
    .axis_cmd     (axis_cmd),
    .tick         (tick),
    .load         (load),
    .run          (run),
    .buffer_ready (buffer_ready),
    .move_done    (move_done)
  );

  for (genvar a = 0; a < NUM_AXES; a++) begin : g_axis
    assign dir[a] = axis_cmd[a].dir; // Follows the slot being read

    dda_axis dda_axis_i (
      .CLK      (CLK),
      .resetn   (resetn),
      .axis_cmd (axis_cmd[a]),
      .tick     (tick),
      .load     (load),
      .run      (run),
      .step     (step[a]),
      .position (position[a])
    );
  end

endmodule

// File: design/cmd_decoder.sv
// Host command decoder
`timescale 1ns/1ps

module cmd_decoder import motion_pkg::*, cmd_pkg::*; (
  input  logic                      CLK,
  input  logic                      resetn,
  input  word_t                     word_data,
  input  logic                      word_valid,
  input  position_t [NUM_AXES-1:0]  position,
  output word_t                     reply_data,
  output axis_mask_t                enable,
  output divisor_t                  divisor,
  output move_rec_t                 move_wr,
  output slot_idx_t                 move_wr_slot,
  output logic                      move_wr_push
);

  typedef enum logic {
    ST_IDLE,
    ST_COLLECT
  } dec_state_t;

  dec_state_t                    state;
  opcode_t                       msg_header;
  opcode_t                       opcode;
  logic [2:0]                    word_cnt;   // Words of the current message so far
  logic                          word_valid_q;
  logic                          word_take;
  logic [$clog2(NUM_AXES)-1:0]   ch;
  position_t [NUM_AXES-1:0]      pos_snap;   // Frozen while a move is collected
  slot_idx_t                     wr_slot;

  assign word_take    = word_valid && !word_valid_q; // First cycle of the strobe
  assign opcode       = opcode_t'(word_data[HEADER_MSB:HEADER_LSB]);
  assign ch           = word_data[CHANNEL_LSB +: $clog2(NUM_AXES)];
  assign move_wr_slot = wr_slot;

  // Move record assembly
  always_ff @(posedge CLK) begin
    if (word_take) begin
      if (state == ST_IDLE) begin
        move_wr.dir <= word_data[NUM_AXES-1:0];
      end else begin
        if (word_cnt == 3'd1) begin
          move_wr.duration <= word_data[$bits(duration_t)-1:0];
        end
        for (int a = 0; a < NUM_AXES; a++) begin
          if (word_cnt == 2 + 2 * a) move_wr.rate[a] <= word_data;
          if (word_cnt == 3 + 2 * a) move_wr.rate_chg[a] <= word_data;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state        <= ST_IDLE;
      msg_header   <= opcode_t'(8'h00);
      word_cnt     <= '0;
      word_valid_q <= 1'b0;
      reply_data   <= '0;
      enable       <= '0;
      divisor      <= DEFAULT_DIVISOR;
      wr_slot      <= '0;
      move_wr_push <= 1'b0;
      pos_snap     <= '0;
    end else begin
      word_valid_q <= word_valid;
      move_wr_push <= 1'b0;
      if (move_wr_push) wr_slot <= wr_slot + 1'b1; // Next free slot in turn
      if (state == ST_IDLE) pos_snap <= position;

      if (word_take) begin
        reply_data <= '0;
        if (state == ST_IDLE) begin
          msg_header <= opcode;
          word_cnt   <= 3'd1;
          case (opcode)
            CMD_COORDINATED_STEP: state <= ST_COLLECT;
            CMD_MOTOR_ENABLE:     enable <= word_data[NUM_AXES-1:0];
            CMD_CLK_DIVISOR:      divisor <= word_data[7:0];
            CMD_API_VERSION: begin
              reply_data <= {32'd0, VERSION_DEVEL, VERSION_MAJOR,
                             VERSION_MINOR, VERSION_PATCH};
            end
            CMD_READ_POSITION: begin
              reply_data <= {{32{pos_snap[ch][31]}}, pos_snap[ch]}; // Sign extended
            end
            default: reply_data <= '0;
          endcase
        end else begin
          word_cnt <= word_cnt + 3'd1;
          // Last rate change word closes the move
          if (word_cnt == MOVE_WORDS - 1) begin
            state        <= ST_IDLE;
            move_wr_push <= 1'b1;
          end
        end
      end
    end
  end

  // A push only ends a complete move message
  a_push_complete: assert property (@(posedge CLK) disable iff (resetn)
    move_wr_push |-> (msg_header == CMD_COORDINATED_STEP) && (word_cnt == MOVE_WORDS));

endmodule

// File: design/move_queue.sv
// Move buffer and sequencer
`timescale 1ns/1ps

module move_queue import motion_pkg::*; (
  input  logic                      CLK,
  input  logic                      resetn,
  input  divisor_t                  divisor,
  input  move_rec_t                 move_wr,
  input  slot_idx_t                 move_wr_slot,
  input  logic                      move_wr_push,
  output axis_cmd_t [NUM_AXES-1:0]  axis_cmd,
  output logic                      tick,
  output logic                      load,
  output logic                      run,
  output logic                      buffer_ready,
  output logic                      move_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOADING,
    ST_EXECUTING
  } seq_state_t;

  seq_state_t              state;
  move_rec_t               slots [BUFFER_SIZE];
  logic [BUFFER_SIZE-1:0]  slot_ready;   // Toggled by each push
  logic [BUFFER_SIZE-1:0]  slot_done;    // Toggled when the move retires
  logic [BUFFER_SIZE-1:0]  slot_full;
  slot_idx_t               rd_slot;
  duration_t               dur_cnt;      // Ticks left in the move
  divisor_t                div_cnt;
  logic                    rd_full;
  logic                    finish;

  assign slot_full    = slot_ready ^ slot_done;
  assign buffer_ready = ~&slot_full;
  assign rd_full      = slot_full[rd_slot];
  assign run          = (state == ST_EXECUTING);
  assign load         = tick && rd_full && (state != ST_EXECUTING);
  assign finish       = run && ((dur_cnt == '0) || (tick && dur_cnt == duration_t'(1)));

  always_comb begin
    for (int a = 0; a < NUM_AXES; a++) begin
      axis_cmd[a].rate     = slots[rd_slot].rate[a];
      axis_cmd[a].rate_chg = slots[rd_slot].rate_chg[a];
      axis_cmd[a].dir      = slots[rd_slot].dir[a];
    end
  end

  always_ff @(posedge CLK) begin
    if (move_wr_push) slots[move_wr_slot] <= move_wr;
  end

  // Divisor of 0 or 1 ticks every clock
  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else if ({1'b0, div_cnt} + 9'd1 >= {1'b0, divisor}) begin
      div_cnt <= '0;
      tick    <= 1'b1;
    end else begin
      div_cnt <= div_cnt + 8'd1;
      tick    <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= ST_IDLE;
      slot_ready <= '0;
      slot_done  <= '0;
      rd_slot    <= '0;
      dur_cnt    <= '0;
      move_done  <= 1'b0;
    end else begin
      move_done <= 1'b0;
      if (move_wr_push) slot_ready[move_wr_slot] <= ~slot_ready[move_wr_slot];
      case (state)
        ST_IDLE, ST_LOADING: begin
          if (load) begin
            state   <= ST_EXECUTING;
            dur_cnt <= slots[rd_slot].duration;
          end else begin
            state <= rd_full ? ST_LOADING : ST_IDLE; // Wait for the next tick
          end
        end
        ST_EXECUTING: begin
          if (finish) begin
            move_done          <= 1'b1;
            slot_done[rd_slot] <= ~slot_done[rd_slot]; // Free the slot
            rd_slot            <= rd_slot + 1'b1;
            state              <= ST_IDLE;
          end else if (tick) begin
            dur_cnt <= dur_cnt - 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  a_run_load_excl: assert property (@(posedge CLK) disable iff (resetn)
    !(run && load));

  a_done_single: assert property (@(posedge CLK) disable iff (resetn)
    move_done |=> !move_done);

  // Decoder must never overwrite a slot still waiting or running
  a_push_free_slot: assert property (@(posedge CLK) disable iff (resetn)
    move_wr_push |-> !slot_full[move_wr_slot]);

endmodule

// File: design/dda_axis.sv
// Single axis DDA
`timescale 1ns/1ps

module dda_axis import motion_pkg::*; (
  input  logic       CLK,
  input  logic       resetn,
  input  axis_cmd_t  axis_cmd,
  input  logic       tick,
  input  logic       load,
  input  logic       run,
  output logic       step,
  output position_t  position
);

  logic [63:0]  acc;
  logic [64:0]  sum;       // Bit 64 is the step carry
  dda_word_t    rate;
  dda_word_t    rate_chg;
  logic         dir_q;

  assign sum = {1'b0, acc} + {1'b0, rate};

  // Move parameters latched at load, rate ramps each tick
  always_ff @(posedge CLK) begin
    if (load) begin
      rate     <= axis_cmd.rate;
      rate_chg <= axis_cmd.rate_chg;
      dir_q    <= axis_cmd.dir;
    end else if (run && tick) begin
      rate <= rate + rate_chg;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      acc      <= '0;
      step     <= 1'b0;
      position <= '0;
    end else begin
      step <= 1'b0;
      if (load) begin
        acc <= '0;
      end else if (run && tick) begin
        acc <= sum[63:0];
        if (sum[64]) begin
          step     <= 1'b1;
          position <= dir_q ? position + 32'sd1 : position - 32'sd1;
        end
      end
    end
  end

endmodule

// File: design/cmd_pkg.sv
// Host command protocol
package cmd_pkg;

  typedef logic [63:0] word_t;

  // Opcodes in the header byte
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_READ_POSITION    = 8'h03,
    CMD_MOTOR_ENABLE     = 8'h0a,
    CMD_CLK_DIVISOR      = 8'h20,
    CMD_API_VERSION      = 8'hfe
  } opcode_t;

  // Header word layout
  localparam int HEADER_MSB  = 63;
  localparam int HEADER_LSB  = 56;
  localparam int CHANNEL_LSB = 48; // Axis select for position readback

  // Version reply bytes
  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd3;
  localparam logic [7:0] VERSION_DEVEL = 8'd0;

  // Header, duration, then rate and rate change for each of two axes
  localparam int MOVE_WORDS = 6;

endpackage

// File: design/motion_pkg.sv
// Motion types and sizes
package motion_pkg;

  localparam int NUM_AXES    = 2;
  localparam int BUFFER_SIZE = 2; // Move slots

  // Slot index and per-axis bit masks
  typedef logic [$clog2(BUFFER_SIZE)-1:0] slot_idx_t;
  typedef logic [NUM_AXES-1:0]            axis_mask_t; // Direction, enable, step

  // DDA rate words are signed, added as plain 64-bit sums
  typedef logic signed [63:0] dda_word_t;
  typedef logic        [31:0] duration_t; // Ticks per move
  typedef logic signed [31:0] position_t; // Steps from reset
  typedef logic        [7:0]  divisor_t;  // Clocks per DDA tick

  localparam divisor_t DEFAULT_DIVISOR = 8'd32;

  // One buffered coordinated move, 290 bits
  typedef struct packed {
    dda_word_t [NUM_AXES-1:0] rate_chg; // Added to rate after every tick
    dda_word_t [NUM_AXES-1:0] rate;
    duration_t                duration;
    axis_mask_t               dir;      // 1 counts up
  } move_rec_t;

  // Move parameters seen by one axis
  typedef struct packed {
    dda_word_t rate;
    dda_word_t rate_chg;
    logic      dir;
  } axis_cmd_t;

endpackage
